//--- verilog/mem_pkg.sv
`default_nettype none

package mem_pkg;

    typedef enum logic [3:0] {
        OP_PASS,
        OP_LDB,
        OP_LDBU,
        OP_LDH,
        OP_LDHU,
        OP_LDW,
        OP_STB,
        OP_STH,
        OP_STW,
        OP_CSRRD,
        OP_CSRWR,
        OP_CSRXCHG,
        OP_RDCNTVL,
        OP_RDCNTVH
    } mem_op_e;

    // wdata carries the store data, the CSR write data or a plain result.
    typedef struct packed {
        mem_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [13:0] csr_addr;
        logic [31:0] csr_mask;
        logic [4:0]  rd;
        logic        rd_en;
    } ex_mem_t;

    typedef struct packed {
        logic        en;
        logic [13:0] addr;
        logic [31:0] data;
    } csr_write_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic        rd_en;
        logic [31:0] rd_data;
        csr_write_t  csr_write;
        logic        misaligned;
    } mem_wb_t;

    typedef struct packed {
        logic        en;
        logic        we;
        logic [29:0] word_idx;
        logic [3:0]  strobe;
        logic [31:0] wdata;
    } dram_req_t;

    typedef struct packed {
        logic        data_ok;
        logic [31:0] rdata;
    } dram_rsp_t;

    localparam logic [13:0] CSR_CRMD  = 14'h000;
    localparam logic [13:0] CSR_PRMD  = 14'h001;
    localparam logic [13:0] CSR_ESTAT = 14'h005;
    localparam logic [13:0] CSR_SAVE0 = 14'h030;

endpackage

`default_nettype wire

//--- verilog/stage_reg.sv
`default_nettype none
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out
);
    logic live;

    // the slot takes a new item when empty or when its item leaves this cycle.
    assign in_ready = live && (!out_valid || out_ready);

    always_ff @(posedge clk) begin
        if (reset) begin
            live      <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            live <= 1'b1;
            if (in_ready) begin
                out_valid <= in_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out <= in;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out));

endmodule

`default_nettype wire

//--- verilog/lane_align.sv
`default_nettype none
`timescale 1ns/1ps

module lane_align (
    input  mem_pkg::mem_op_e op,
    input  logic [31:0]      addr,
    input  logic [31:0]      wdata,
    input  logic [31:0]      rdata,
    output logic             misaligned,
    output logic [3:0]       strobe,
    output logic [31:0]      lane_wdata,
    output logic [31:0]      load_data
);
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    assign sel_byte = rdata[{addr[1:0], 3'b000} +: 8];
    assign sel_half = addr[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        misaligned = 1'b0;
        strobe     = 4'b0000;
        lane_wdata = wdata;
        load_data  = rdata;
        case (op)
            mem_pkg::OP_LDB:  load_data = {{24{sel_byte[7]}}, sel_byte};
            mem_pkg::OP_LDBU: load_data = {24'b0, sel_byte};
            mem_pkg::OP_LDH: begin
                misaligned = addr[0];
                load_data  = {{16{sel_half[15]}}, sel_half};
            end
            mem_pkg::OP_LDHU: begin
                misaligned = addr[0];
                load_data  = {16'b0, sel_half};
            end
            mem_pkg::OP_LDW:  misaligned = addr[1:0] != 2'b00;
            // store data is copied into every lane and the strobe picks the bytes.
            mem_pkg::OP_STB: begin
                strobe     = 4'b0001 << addr[1:0];
                lane_wdata = {4{wdata[7:0]}};
            end
            mem_pkg::OP_STH: begin
                misaligned = addr[0];
                strobe     = addr[1] ? 4'b1100 : 4'b0011;
                lane_wdata = {2{wdata[15:0]}};
            end
            mem_pkg::OP_STW: begin
                misaligned = addr[1:0] != 2'b00;
                strobe     = 4'b1111;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/csr_unit.sv
`default_nettype none
`timescale 1ns/1ps

module csr_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                rd_en,
    input  logic [13:0]         rd_addr,
    output logic [31:0]         rd_data,
    input  mem_pkg::csr_write_t pending,
    input  logic                commit,
    output logic [63:0]         cnt
);
    logic [31:0] crmd;
    logic [31:0] prmd;
    logic [31:0] estat;
    logic [31:0] save0;
    logic [31:0] stored;
    logic        known;

    always_comb begin
        known = 1'b1;
        case (rd_addr)
            mem_pkg::CSR_CRMD:  stored = crmd;
            mem_pkg::CSR_PRMD:  stored = prmd;
            mem_pkg::CSR_ESTAT: stored = estat;
            mem_pkg::CSR_SAVE0: stored = save0;
            default: begin
                stored = '0;
                known  = 1'b0;
            end
        endcase
    end

    // the write waiting in the write-back slot is newer than the file.
    always_comb begin
        if (!rd_en || !known) begin
            rd_data = '0;
        end else if (pending.en && pending.addr == rd_addr) begin
            rd_data = pending.data;
        end else begin
            rd_data = stored;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd  <= '0;
            prmd  <= '0;
            estat <= '0;
            save0 <= '0;
        end else if (commit && pending.en) begin
            case (pending.addr)
                mem_pkg::CSR_CRMD:  crmd  <= pending.data;
                mem_pkg::CSR_PRMD:  prmd  <= pending.data;
                mem_pkg::CSR_ESTAT: estat <= pending.data;
                mem_pkg::CSR_SAVE0: save0 <= pending.data;
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 64'd1;
        end
    end

    // an uncommitted write must stay visible until the write-back slot releases it.
    assert property (@(posedge clk) disable iff (reset)
        pending.en && !commit |=> $stable(pending));

endmodule

`default_nettype wire

//--- verilog/data_ram.sv
`default_nettype none
`timescale 1ns/1ps

module data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic               clk,
    input  logic               reset,
    input  mem_pkg::dram_req_t req,
    output mem_pkg::dram_rsp_t rsp
);
    localparam int AW = $clog2(RAM_WORDS);

    logic [31:0]   mem [RAM_WORDS];
    logic [AW-1:0] idx;

    // addresses wrap around the depth of the array.
    assign idx = req.word_idx[AW-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (req.en && req.we) begin
            for (int b = 0; b < 4; b++) begin
                if (req.strobe[b]) begin
                    mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp.data_ok <= 1'b0;
        end else begin
            rsp.data_ok <= req.en && !req.we;
        end
    end

    always_ff @(posedge clk) begin
        if (req.en && !req.we) begin
            rsp.rdata <= mem[idx];
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        req.en && !req.we |=> !req.en);

endmodule

`default_nettype wire

//--- verilog/mem_stage.sv
`default_nettype none
`timescale 1ns/1ps

module mem_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               cur_valid,
    input  mem_pkg::ex_mem_t   cur,
    output logic               cur_ready,
    output logic               done_valid,
    output mem_pkg::mem_wb_t   done,
    input  logic               done_ready,
    output mem_pkg::dram_req_t dram_req,
    input  mem_pkg::dram_rsp_t dram_rsp,
    output logic               csr_rd_en,
    output logic [13:0]        csr_rd_addr,
    input  logic [31:0]        csr_rdata,
    input  logic [63:0]        cnt
);
    logic        is_load;
    logic        is_store;
    logic        is_csr;
    logic        is_xchg;
    logic        access;
    logic        load_wait;
    logic        ld_busy;
    logic        ld_have;
    logic [31:0] ld_word;
    logic [31:0] ram_word;
    logic        misaligned;
    logic [3:0]  strobe;
    logic [31:0] lane_wdata;
    logic [31:0] load_data;

    assign is_load  = cur.op inside {mem_pkg::OP_LDB, mem_pkg::OP_LDBU, mem_pkg::OP_LDH,
                                     mem_pkg::OP_LDHU, mem_pkg::OP_LDW};
    assign is_store = cur.op inside {mem_pkg::OP_STB, mem_pkg::OP_STH, mem_pkg::OP_STW};
    assign is_csr   = cur.op inside {mem_pkg::OP_CSRRD, mem_pkg::OP_CSRWR, mem_pkg::OP_CSRXCHG};
    assign is_xchg  = cur.op == mem_pkg::OP_CSRXCHG;
    assign access   = (is_load || is_store) && !misaligned;

    // a captured word is used once the RAM response has gone.
    assign ram_word = ld_have ? ld_word : dram_rsp.rdata;

    lane_align u_lane (
        .op         (cur.op),
        .addr       (cur.addr),
        .wdata      (cur.wdata),
        .rdata      (ram_word),
        .misaligned (misaligned),
        .strobe     (strobe),
        .lane_wdata (lane_wdata),
        .load_data  (load_data)
    );

    assign load_wait  = cur_valid && is_load && access && !ld_have && !dram_rsp.data_ok;
    assign done_valid = cur_valid && !load_wait;
    assign cur_ready  = done_ready && !load_wait;

    // stores write on the edge where they leave, so a stall never repeats a write.
    assign dram_req.en       = cur_valid && access &&
                               (is_load ? (!ld_busy && !ld_have) : done_ready);
    assign dram_req.we       = is_store;
    assign dram_req.word_idx = cur.addr[31:2];
    assign dram_req.strobe   = strobe;
    assign dram_req.wdata    = lane_wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            ld_busy <= 1'b0;
            ld_have <= 1'b0;
        end else if (cur_valid && cur_ready) begin
            ld_busy <= 1'b0;
            ld_have <= 1'b0;
        end else if (dram_rsp.data_ok) begin
            ld_busy <= 1'b0;
            ld_have <= 1'b1;
        end else if (dram_req.en && !dram_req.we) begin
            ld_busy <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (dram_rsp.data_ok) begin
            ld_word <= dram_rsp.rdata;
        end
    end

    assign csr_rd_en   = cur_valid && is_csr;
    assign csr_rd_addr = cur.csr_addr;

    always_comb begin
        case (cur.op)
            mem_pkg::OP_RDCNTVL: done.rd_data = cnt[31:0];
            mem_pkg::OP_RDCNTVH: done.rd_data = cnt[63:32];
            default: begin
                if (is_load) begin
                    done.rd_data = load_data;
                end else if (is_csr) begin
                    done.rd_data = csr_rdata;
                end else begin
                    done.rd_data = cur.wdata;
                end
            end
        endcase
    end

    assign done.rd         = cur.rd;
    assign done.rd_en      = cur.rd_en && !misaligned;
    assign done.misaligned = misaligned;

    // exchange keeps the unmasked bits of the old value.
    assign done.csr_write.en   = cur.op == mem_pkg::OP_CSRWR || is_xchg;
    assign done.csr_write.addr = cur.csr_addr;
    assign done.csr_write.data = is_xchg ? ((csr_rdata & ~cur.csr_mask) |
                                            (cur.wdata & cur.csr_mask)) : cur.wdata;

    assert property (@(posedge clk) disable iff (reset) dram_rsp.data_ok |-> ld_busy);

endmodule

`default_nettype wire

//--- verilog/mem_subsystem.sv
`default_nettype none
`timescale 1ns/1ps

module mem_subsystem #(
    parameter int RAM_WORDS = 256
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    output logic             in_ready,
    input  mem_pkg::ex_mem_t in,
    output logic             out_valid,
    input  logic             out_ready,
    output mem_pkg::mem_wb_t out
);
    logic                cur_valid;
    logic                cur_ready;
    mem_pkg::ex_mem_t    cur;
    logic                done_valid;
    logic                done_ready;
    mem_pkg::mem_wb_t    done;
    mem_pkg::dram_req_t  dram_req;
    mem_pkg::dram_rsp_t  dram_rsp;
    logic                csr_rd_en;
    logic [13:0]         csr_rd_addr;
    logic [31:0]         csr_rdata;
    logic [63:0]         cnt;
    mem_pkg::csr_write_t pending;
    logic                commit;

    // the item held for write-back forwards its CSR write and commits it on leaving.
    assign pending = '{en: out_valid && out.csr_write.en,
                       addr: out.csr_write.addr,
                       data: out.csr_write.data};
    assign commit  = out_valid && out_ready;

    stage_reg #(.payload_t(mem_pkg::ex_mem_t)) u_ex_reg (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_ready(in_ready), .in(in),
        .out_valid(cur_valid), .out_ready(cur_ready), .out(cur)
    );

    mem_stage u_mem (
        .clk(clk), .reset(reset),
        .cur_valid(cur_valid), .cur(cur), .cur_ready(cur_ready),
        .done_valid(done_valid), .done(done), .done_ready(done_ready),
        .dram_req(dram_req), .dram_rsp(dram_rsp),
        .csr_rd_en(csr_rd_en), .csr_rd_addr(csr_rd_addr), .csr_rdata(csr_rdata),
        .cnt(cnt)
    );

    stage_reg #(.payload_t(mem_pkg::mem_wb_t)) u_wb_reg (
        .clk(clk), .reset(reset),
        .in_valid(done_valid), .in_ready(done_ready), .in(done),
        .out_valid(out_valid), .out_ready(out_ready), .out(out)
    );

    csr_unit u_csr (
        .clk(clk), .reset(reset),
        .rd_en(csr_rd_en), .rd_addr(csr_rd_addr), .rd_data(csr_rdata),
        .pending(pending), .commit(commit), .cnt(cnt)
    );

    data_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
        .clk(clk), .reset(reset), .req(dram_req), .rsp(dram_rsp)
    );

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- bench/tb_mem_subsystem.sv
`default_nettype none
`timescale 1ns/1ps

module tb_mem_subsystem;
    localparam int PERIOD_NS    = 4;
    localparam int RESET_CYCLES = 16;
    localparam int RAM_WORDS    = 256;
    localparam int N_PASS       = 8;
    localparam int N_LOADSTORE  = 46;
    localparam int N_MISALIGN   = 14;
    localparam int N_CSR        = 19;
    localparam int N_COUNTER    = 7;
    localparam int N_RANDOM     = 200;
    localparam int N_ITEMS      = N_PASS + N_LOADSTORE + N_MISALIGN + N_CSR +
                                  N_COUNTER + N_RANDOM;

    typedef struct packed {
        mem_pkg::mem_wb_t wb;
        logic             check_data;
        logic             cnt_low;
    } expect_t;

    logic             clk;
    logic             reset;
    logic             in_valid;
    logic             in_ready;
    mem_pkg::ex_mem_t in;
    logic             out_valid;
    logic             out_ready;
    mem_pkg::mem_wb_t out;

    logic [7:0]  mem_model [4*RAM_WORDS];
    logic [31:0] csr_model [4];
    expect_t     exp_q [$];
    logic [31:0] rng;
    logic [31:0] rdy_rng;
    logic        random_ready;
    logic        ready_level;
    logic [31:0] last_cnt;
    int          n_sent;
    int          n_out;

    tb_clock #(.PERIOD_NS(PERIOD_NS)) u_clock (.clk(clk));

    mem_subsystem #(.RAM_WORDS(RAM_WORDS)) u_mem_subsystem (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_ready(in_ready), .in(in),
        .out_valid(out_valid), .out_ready(out_ready), .out(out)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            $display("FAIL %0t %s got %0h expected %0h", $time, name, got, want);
            $display("Test FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    function automatic logic misaligned_for(input mem_pkg::mem_op_e op,
                                            input logic [31:0] addr);
        case (op)
            mem_pkg::OP_LDH, mem_pkg::OP_LDHU, mem_pkg::OP_STH: return addr[0];
            mem_pkg::OP_LDW, mem_pkg::OP_STW: return addr[1:0] != 2'b00;
            default: return 1'b0;
        endcase
    endfunction

    // the byte model covers the whole RAM, so the low ten address bits pick a byte.
    function automatic logic [31:0] load_value(input mem_pkg::mem_op_e op, input logic [9:0] a);
        logic [7:0]  b;
        logic [15:0] h;
        b = mem_model[a];
        h = {mem_model[a + 10'd1], mem_model[a]};
        case (op)
            mem_pkg::OP_LDB:  return {{24{b[7]}}, b};
            mem_pkg::OP_LDBU: return {24'h0, b};
            mem_pkg::OP_LDH:  return {{16{h[15]}}, h};
            mem_pkg::OP_LDHU: return {16'h0, h};
            default: return {mem_model[a + 10'd3], mem_model[a + 10'd2], h};
        endcase
    endfunction

    function automatic void store_bytes(input mem_pkg::mem_op_e op, input logic [9:0] a,
                                        input logic [31:0] d);
        mem_model[a] = d[7:0];
        if (op != mem_pkg::OP_STB) begin
            mem_model[a + 10'd1] = d[15:8];
        end
        if (op == mem_pkg::OP_STW) begin
            mem_model[a + 10'd2] = d[23:16];
            mem_model[a + 10'd3] = d[31:24];
        end
    endfunction

    function automatic int csr_slot(input logic [13:0] addr);
        case (addr)
            mem_pkg::CSR_CRMD:  return 0;
            mem_pkg::CSR_PRMD:  return 1;
            mem_pkg::CSR_ESTAT: return 2;
            mem_pkg::CSR_SAVE0: return 3;
            default: return -1;
        endcase
    endfunction

    // items leave in order, so the models advance once per item as it is sent.
    function automatic expect_t predict(input mem_pkg::ex_mem_t it);
        expect_t     e;
        int          slot;
        logic [31:0] old;
        e = '0;
        e.wb.rd         = it.rd;
        e.wb.rd_en      = it.rd_en;
        e.wb.rd_data    = it.wdata;
        e.wb.misaligned = misaligned_for(it.op, it.addr);
        e.check_data    = !e.wb.misaligned;
        slot = csr_slot(it.csr_addr);
        old  = (slot >= 0) ? csr_model[slot] : 32'h0;
        if (e.wb.misaligned) begin
            e.wb.rd_en = 1'b0;
        end else begin
            case (it.op)
                mem_pkg::OP_LDB, mem_pkg::OP_LDBU, mem_pkg::OP_LDH, mem_pkg::OP_LDHU,
                mem_pkg::OP_LDW: e.wb.rd_data = load_value(it.op, it.addr[9:0]);
                mem_pkg::OP_STB, mem_pkg::OP_STH,
                mem_pkg::OP_STW: store_bytes(it.op, it.addr[9:0], it.wdata);
                mem_pkg::OP_CSRRD: e.wb.rd_data = old;
                mem_pkg::OP_CSRWR, mem_pkg::OP_CSRXCHG: begin
                    e.wb.rd_data        = old;
                    e.wb.csr_write.en   = 1'b1;
                    e.wb.csr_write.addr = it.csr_addr;
                    if (it.op == mem_pkg::OP_CSRWR) begin
                        e.wb.csr_write.data = it.wdata;
                    end else begin
                        e.wb.csr_write.data = (old & ~it.csr_mask) | (it.wdata & it.csr_mask);
                    end
                    if (slot >= 0) begin
                        csr_model[slot] = e.wb.csr_write.data;
                    end
                end
                mem_pkg::OP_RDCNTVL: begin
                    e.check_data = 1'b0;
                    e.cnt_low    = 1'b1;
                end
                mem_pkg::OP_RDCNTVH: e.wb.rd_data = 32'h0;
                default: begin
                end
            endcase
        end
        return e;
    endfunction

    function automatic mem_pkg::ex_mem_t make_item(input mem_pkg::mem_op_e op,
                                                   input logic [31:0] addr,
                                                   input logic [31:0] wdata,
                                                   input logic [13:0] csr_addr,
                                                   input logic [31:0] mask);
        mem_pkg::ex_mem_t it;
        logic [31:0]      r;
        r = next_rand();
        it.op       = op;
        it.addr     = addr;
        it.wdata    = wdata;
        it.csr_addr = csr_addr;
        it.csr_mask = mask;
        it.rd       = r[4:0];
        it.rd_en    = 1'b1;
        return it;
    endfunction

    task automatic send(input mem_pkg::ex_mem_t it);
        logic taken;
        exp_q.push_back(predict(it));
        n_sent++;
        @(negedge clk);
        in_valid = 1'b1;
        in       = it;
        taken    = 1'b0;
        while (!taken) begin
            @(posedge clk);
            taken = in_ready;
        end
    endtask

    task automatic idle();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        idle();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic compare_output(input expect_t e);
        n_out++;
        check("out.rd", 64'(out.rd), 64'(e.wb.rd));
        check("out.rd_en", 64'(out.rd_en), 64'(e.wb.rd_en));
        check("out.misaligned", 64'(out.misaligned), 64'(e.wb.misaligned));
        check("out.csr_write.en", 64'(out.csr_write.en), 64'(e.wb.csr_write.en));
        if (e.wb.csr_write.en) begin
            check("out.csr_write.addr", 64'(out.csr_write.addr), 64'(e.wb.csr_write.addr));
            check("out.csr_write.data", 64'(out.csr_write.data), 64'(e.wb.csr_write.data));
        end
        if (e.check_data) begin
            check("out.rd_data", 64'(out.rd_data), 64'(e.wb.rd_data));
        end
        if (e.cnt_low) begin
            check("rdcntvl_rising", 64'(out.rd_data > last_cnt), 64'd1);
            last_cnt = out.rd_data;
        end
    endtask

    task automatic pass_through();
        mem_pkg::ex_mem_t it;
        for (int i = 0; i < N_PASS; i++) begin
            it = make_item(mem_pkg::OP_PASS, next_rand(), next_rand(), mem_pkg::CSR_SAVE0,
                           next_rand());
            it.rd_en = i[0];
            send(it);
        end
        wait_drain();
    endtask

    task automatic loads_and_stores();
        mem_pkg::mem_op_e st [3];
        mem_pkg::mem_op_e ld [5];
        logic [31:0]      base;
        int               lstep;
        st = '{mem_pkg::OP_STB, mem_pkg::OP_STH, mem_pkg::OP_STW};
        ld = '{mem_pkg::OP_LDB, mem_pkg::OP_LDBU, mem_pkg::OP_LDH, mem_pkg::OP_LDHU,
               mem_pkg::OP_LDW};
        for (int s = 0; s < 3; s++) begin
            base = next_rand() & 32'hffff_fffc;
            for (int off = 0; off < 4; off += (1 << s)) begin
                send(make_item(st[s], base + off, next_rand(), mem_pkg::CSR_CRMD, 32'h0));
            end
            for (int l = 0; l < 5; l++) begin
                lstep = (l < 2) ? 1 : ((l < 4) ? 2 : 4);
                for (int off = 0; off < 4; off += lstep) begin
                    send(make_item(ld[l], base + off, next_rand(), mem_pkg::CSR_CRMD, 32'h0));
                end
            end
        end
        wait_drain();
    endtask

    task automatic misaligned_access();
        logic [31:0] base;
        base = next_rand() & 32'hffff_fffc;
        send(make_item(mem_pkg::OP_STW, base, next_rand(), mem_pkg::CSR_CRMD, 32'h0));
        for (int off = 1; off < 4; off++) begin
            send(make_item(mem_pkg::OP_LDW, base + off, 32'h0, mem_pkg::CSR_CRMD, 32'h0));
            send(make_item(mem_pkg::OP_STW, base + off, next_rand(), mem_pkg::CSR_CRMD, 32'h0));
        end
        for (int off = 1; off < 4; off += 2) begin
            send(make_item(mem_pkg::OP_LDH, base + off, 32'h0, mem_pkg::CSR_CRMD, 32'h0));
            send(make_item(mem_pkg::OP_LDHU, base + off, 32'h0, mem_pkg::CSR_CRMD, 32'h0));
            send(make_item(mem_pkg::OP_STH, base + off, next_rand(), mem_pkg::CSR_CRMD, 32'h0));
        end
        // the word must still hold what the aligned store wrote.
        send(make_item(mem_pkg::OP_LDW, base, 32'h0, mem_pkg::CSR_CRMD, 32'h0));
        wait_drain();
    endtask

    task automatic csr_access();
        logic [13:0] csrs [4];
        csrs = '{mem_pkg::CSR_CRMD, mem_pkg::CSR_PRMD, mem_pkg::CSR_ESTAT, mem_pkg::CSR_SAVE0};
        for (int i = 0; i < 4; i++) begin
            send(make_item(mem_pkg::OP_CSRWR, 32'h0, next_rand(), csrs[i], 32'h0));
        end
        for (int i = 0; i < 4; i++) begin
            send(make_item(mem_pkg::OP_CSRRD, 32'h0, 32'h0, csrs[i], 32'h0));
        end
        for (int i = 0; i < 4; i++) begin
            send(make_item(mem_pkg::OP_CSRXCHG, 32'h0, next_rand(), csrs[i], next_rand()));
        end
        wait_drain();
        // the exchange reads the write that still waits in the write-back slot.
        ready_level = 1'b0;
        send(make_item(mem_pkg::OP_CSRWR, 32'h0, next_rand(), mem_pkg::CSR_SAVE0, 32'h0));
        send(make_item(mem_pkg::OP_CSRXCHG, 32'h0, next_rand(), mem_pkg::CSR_SAVE0,
                       next_rand()));
        idle();
        repeat (6) @(negedge clk);
        check("in_ready", 64'(in_ready), 64'd0);
        check("out_valid", 64'(out_valid), 64'd1);
        @(posedge clk);
        ready_level = 1'b1;
        send(make_item(mem_pkg::OP_CSRRD, 32'h0, 32'h0, mem_pkg::CSR_SAVE0, 32'h0));
        send(make_item(mem_pkg::OP_CSRRD, 32'h0, 32'h0, 14'h002, 32'h0));
        send(make_item(mem_pkg::OP_CSRWR, 32'h0, next_rand(), 14'h7ff, 32'h0));
        send(make_item(mem_pkg::OP_CSRXCHG, 32'h0, next_rand(), 14'h031, next_rand()));
        send(make_item(mem_pkg::OP_CSRRD, 32'h0, 32'h0, 14'h7ff, 32'h0));
        wait_drain();
    endtask

    task automatic counter_reads();
        send(make_item(mem_pkg::OP_RDCNTVH, 32'h0, 32'h0, mem_pkg::CSR_CRMD, 32'h0));
        for (int i = 0; i < N_COUNTER - 1; i++) begin
            send(make_item(mem_pkg::OP_RDCNTVL, 32'h0, 32'h0, mem_pkg::CSR_CRMD, 32'h0));
        end
        wait_drain();
    endtask

    task automatic random_traffic();
        logic [13:0]      csrs [5];
        logic [31:0]      r;
        mem_pkg::ex_mem_t it;
        csrs = '{mem_pkg::CSR_CRMD, mem_pkg::CSR_PRMD, mem_pkg::CSR_ESTAT, mem_pkg::CSR_SAVE0,
                 14'h02a};
        random_ready = 1'b1;
        for (int i = 0; i < N_RANDOM; i++) begin
            r = next_rand();
            // upper address bits stay random to exercise the wrap while a 64-byte window gets reuse.
            it = make_item(mem_pkg::mem_op_e'(r[3:0] % 4'd12), next_rand() & 32'hffff_fc3f,
                           next_rand(), csrs[r[6:4] % 3'd5], next_rand());
            send(it);
            if (r[9:8] == 2'b00) begin
                idle();
            end
        end
        wait_drain();
        random_ready = 1'b0;
    endtask

    // out_ready follows either a fixed level or a random pattern.
    initial begin
        out_ready = 1'b0;
        rdy_rng   = 32'h84fb;
        forever begin
            @(negedge clk);
            rdy_rng   = xorshift(rdy_rng);
            out_ready = random_ready ? rdy_rng[0] : ready_level;
        end
    end

    initial begin
        n_out    = 0;
        last_cnt = '0;
        forever begin
            @(posedge clk);
            if (!reset && out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("an item left the DUT at %0t with nothing outstanding", $time);
                    $display("Test FAILED");
                    $fatal(1, "unexpected output item");
                end else begin
                    compare_output(exp_q.pop_front());
                end
            end
        end
    end

    initial begin
        #(PERIOD_NS * (RESET_CYCLES + 20 * N_ITEMS));
        $display("timeout: the DUT stopped moving items, %0d of %0d came out", n_out, n_sent);
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        reset        = 1'b1;
        in_valid     = 1'b0;
        in           = '0;
        rng          = 32'h84fb;
        random_ready = 1'b0;
        ready_level  = 1'b1;
        n_sent       = 0;
        for (int i = 0; i < 4 * RAM_WORDS; i++) begin
            mem_model[i] = 8'h00;
        end
        for (int i = 0; i < 4; i++) begin
            csr_model[i] = 32'h0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        pass_through();
        loads_and_stores();
        misaligned_access();
        csr_access();
        counter_reads();
        random_traffic();
        repeat (8) @(posedge clk);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- mem_subsystem.f
verilog/mem_pkg.sv
verilog/stage_reg.sv
verilog/lane_align.sv
verilog/csr_unit.sv
verilog/data_ram.sv
verilog/mem_stage.sv
verilog/mem_subsystem.sv
bench/tb_clock.sv
bench/tb_mem_subsystem.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; the exit status is the test result.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_mem_subsystem -f mem_subsystem.f \
        --Mdir obj_dir -o tb_mem_subsystem; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_mem_subsystem
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation ended with status $status"
    exit "$status"
fi

exit 0
